// File: dv/cart_testdata.txt
# op arg_a arg_b expect name  (W addr data sst_act, R addr 0 prg_addr, P ppu mir_v {a10,ce})
# S sst_addr data 0, Q sst_addr 0 rdata, X reset 0 0 0
R 8000 0 00000 rd_bank0_lo
R 9a5c 0 01a5c rd_bank0_mid
R c123 0 3c123 rd_fixed_lo
R fffc 0 3fffc rd_fixed_hi
W c000 05 0 bank_wr_5
R 8010 0 14010 rd_bank5
R b7f1 0 177f1 rd_bank5_hi
R e0e0 0 3e0e0 rd_fixed_after_wr
W a000 0a 0 ignored_wr
R 8123 0 14123 rd_after_ignored
P 0400 1 3 mir_v_a10
P 0800 0 3 mir_h_a10
P 2400 0 0 mir_h_ce
W 9000 10 0 mirror_wr_1
P 2000 0 2 mir_override_ce
P 0800 1 3 mir_override_v
Q 00 0 c5 sst_regs
Q 7f 0 47 sst_id
Q 20 0 ff sst_other
S 00 0a 0 sst_load
Q 00 0 0a sst_readback
R 8004 0 28004 rd_sst_bank
P 0400 0 1 sst_mir_off
W c000 03 1 bank_wr_during_sst
W 9000 10 1 mirror_wr_during_sst
Q 00 0 0a sst_unchanged
R 8abc 0 28abc rd_bank_unchanged
W 9000 10 0 mirror_wr_2
W c000 07 0 bank_wr_7
X 0 0 0 mid_reset
R 8321 0 00321 rd_reset_bank0
R c444 0 3c444 rd_reset_fixed
P 0400 1 3 reset_mir_v
P 0400 0 1 reset_mir_h

// File: filelist.f
source/cart_pkg.sv
source/cpu_req_if.sv
source/cpu_req_port.sv
source/mapper_071.sv
source/prg_fetch.sv
source/cart_top.sv
dv/cart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cart testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module cart_tb -o cart_sim \
	> build.log 2>&1 && ./obj_dir/cart_sim > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: dv/cart_tb.sv
`timescale 1ns/1ns

module cart_tb
	import cart_pkg::*;
();

	localparam int CLK_PERIOD = 100;

	logic      m2;
	logic      reset;
	logic      cpu_valid;
	logic      cpu_ready;
	cpu_addr_t cpu_addr;
	logic      cpu_rw;
	cpu_data_t cpu_wdata;
	logic      rsp_valid;
	logic      rsp_ready;
	cpu_data_t rsp_data;
	prg_addr_t prg_mem_addr;
	cpu_data_t prg_mem_rdata;
	prg_addr_t mem_addr_q;
	ppu_addr_t ppu_addr;
	logic      cfg_mir_v;
	logic      ciram_a10;
	logic      ciram_ce;
	logic      sst_act;
	logic      sst_we;
	sst_addr_t sst_addr;
	cpu_data_t sst_wdata;
	cpu_data_t sst_rdata;

	// Parsed test data, one entry per line
	string       ops[$];
	logic [31:0] arg_a[$];
	logic [31:0] arg_b[$];
	logic [31:0] arg_exp[$];
	string       names[$];

	// Reads still waiting for their response, oldest first
	cpu_data_t   exp_data[$];
	string       exp_name[$];

	// Read addresses not yet seen on the PRG bus
	prg_addr_t   exp_addr[$];
	string       addr_name[$];
	prg_addr_t   seen_addr;

	logic [31:0] lfsr_state;
	logic        held_valid;
	cpu_data_t   held_data;
	logic        loaded;

	cart_top dut (.*);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Bank bits folded into the high nibble of each byte
	function automatic cpu_data_t mem_byte(input prg_addr_t a);
		return {a[17:14] ^ a[7:4], a[3:0]};
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at first failure");
	endtask

	// Drive one CPU request and return on the edge that takes it
	task automatic cpu_op(input cpu_addr_t addr, input logic rw, input cpu_data_t data,
		input logic sst);
		@(negedge m2);
		cpu_valid = 1'b1;
		cpu_addr  = addr;
		cpu_rw    = rw;
		cpu_wdata = data;
		sst_act   = sst;
		#10;
		while (!cpu_ready)
		begin
			@(negedge m2);
			#10;
		end
		@(posedge m2);
	endtask

	task automatic cpu_idle();
		@(negedge m2);
		cpu_valid = 1'b0;
	endtask

	// Wait for all reads to answer, ends on a falling edge
	task automatic drain();
		cpu_idle();
		while (exp_data.size() != 0)
			@(posedge m2);
		repeat (2) @(negedge m2);
	endtask

	initial
	begin
		m2 = 1'b0;
		forever #(CLK_PERIOD / 2) m2 = ~m2;
	end

	// Synchronous PRG memory, data one cycle after the address
	always @(posedge m2)
		mem_addr_q <= prg_mem_addr;

	always @(negedge m2)
		prg_mem_rdata <= mem_byte(mem_addr_q);

	// Each new address on the PRG bus must be the next expected read
	always @(negedge m2)
	begin
		if (prg_mem_addr !== seen_addr)
		begin
			// Repeated reads of one address leave the bus unchanged
			while (exp_addr.size() != 0 && exp_addr[0] == seen_addr)
			begin
				void'(exp_addr.pop_front());
				void'(addr_name.pop_front());
			end
			assert (exp_addr.size() != 0)
			else fail_now("The PRG memory address changed with no read outstanding");
			assert (prg_mem_addr == exp_addr[0])
			else fail_now($sformatf("[ERROR] %s expected %h actual %h",
				addr_name[0], exp_addr[0], prg_mem_addr));
			void'(exp_addr.pop_front());
			void'(addr_name.pop_front());
			seen_addr = prg_mem_addr;
		end
	end

	// Random back-pressure and in-order response check
	initial
	begin
		lfsr_state = 32'h4f33;
		held_valid = 1'b0;
		held_data  = '0;
		rsp_ready  = 1'b0;
		forever
		begin
			@(negedge m2);
			lfsr_state = lfsr_step(lfsr_state);
			rsp_ready  = lfsr_state[0];
			#10;
			if (held_valid)
				assert (rsp_valid && rsp_data == held_data)
				else fail_now($sformatf("[ERROR] stalled_response expected %h actual %h",
					held_data, rsp_data));
			if (rsp_valid && rsp_ready)
			begin
				assert (exp_data.size() != 0)
				else fail_now("A read response came out with no read outstanding");
				assert (rsp_data == exp_data[0])
				else fail_now($sformatf("[ERROR] %s expected %h actual %h",
					exp_name[0], exp_data[0], rsp_data));
				void'(exp_data.pop_front());
				void'(exp_name.pop_front());
			end
			held_valid = rsp_valid && !rsp_ready;
			held_data  = rsp_data;
		end
	end

	// Watchdog scaled to the number of test lines
	initial
	begin
		wait (loaded);
		#(ops.size() * 40 * CLK_PERIOD);
		fail_now($sformatf("Timeout, the run did not finish within %0d cycles",
			ops.size() * 40));
	end

	initial
	begin
		int          fd;
		int          cnt;
		string       line;
		string       op;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;

		reset         = 1'b1;
		cpu_valid     = 1'b0;
		cpu_addr      = '0;
		cpu_rw        = 1'b1;
		cpu_wdata     = '0;
		prg_mem_rdata = '0;
		ppu_addr      = '0;
		cfg_mir_v     = 1'b0;
		sst_act       = 1'b0;
		sst_we        = 1'b0;
		sst_addr      = '0;
		sst_wdata     = '0;
		loaded        = 1'b0;

		fd = $fopen("dv/cart_testdata.txt", "r");
		if (fd == 0)
			fail_now("Could not open dv/cart_testdata.txt");
		while (!$feof(fd))
		begin
			line = "";
			cnt  = $fgets(line, fd);
			// Comment and blank lines do not scan to five fields
			if (cnt > 0 && $sscanf(line, "%s %h %h %h %s", op, a, b, c, name) == 5)
			begin
				ops.push_back(op);
				arg_a.push_back(a);
				arg_b.push_back(b);
				arg_exp.push_back(c);
				names.push_back(name);
			end
		end
		$fclose(fd);
		loaded = 1'b1;

		repeat (2) @(negedge m2);
		reset = 1'b0;

		foreach (ops[i])
		begin
			case (ops[i])
				"W":
				begin
					cpu_op(arg_a[i][15:0], 1'b0, arg_b[i][7:0], arg_exp[i][0]);
					// Keep the save state active until the mapper sees the write
					if (arg_exp[i][0])
					begin
						cpu_idle();
						@(posedge m2);
						@(negedge m2);
						sst_act = 1'b0;
					end
				end
				"R":
				begin
					cpu_op(arg_a[i][15:0], 1'b1, 8'h00, 1'b0);
					exp_data.push_back(mem_byte(arg_exp[i][17:0]));
					exp_name.push_back(names[i]);
					exp_addr.push_back(arg_exp[i][17:0]);
					addr_name.push_back(names[i]);
				end
				"P":
				begin
					drain();
					ppu_addr  = arg_a[i][13:0];
					cfg_mir_v = arg_b[i][0];
					#10;
					assert ({ciram_a10, ciram_ce} == arg_exp[i][1:0])
					else fail_now($sformatf("[ERROR] %s expected %b actual %b",
						names[i], arg_exp[i][1:0], {ciram_a10, ciram_ce}));
				end
				"S":
				begin
					drain();
					sst_act   = 1'b1;
					sst_we    = 1'b1;
					sst_addr  = arg_a[i][7:0];
					sst_wdata = arg_b[i][7:0];
					@(negedge m2);
					sst_act = 1'b0;
					sst_we  = 1'b0;
				end
				"Q":
				begin
					drain();
					sst_addr = arg_a[i][7:0];
					#10;
					assert (sst_rdata == arg_exp[i][7:0])
					else fail_now($sformatf("[ERROR] %s expected %h actual %h",
						names[i], arg_exp[i][7:0], sst_rdata));
				end
				"X":
				begin
					drain();
					reset = 1'b1;
					repeat (2) @(negedge m2);
					reset = 1'b0;
				end
				default:
					fail_now($sformatf("Unknown operation %s in the test data", ops[i]));
			endcase
		end

		drain();
		$display("sim passed");
		$finish;
	end

endmodule

// File: source/cart_top.sv
`timescale 1ns/1ns

module cart_top
	import cart_pkg::*;
(
	input  logic      m2,
	input  logic      reset,
	// CPU bus requests
	input  logic      cpu_valid,
	output logic      cpu_ready,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_rw,
	input  cpu_data_t cpu_wdata,
	// Read responses
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output cpu_data_t rsp_data,
	// External PRG memory
	output prg_addr_t prg_mem_addr,
	input  cpu_data_t prg_mem_rdata,
	// PPU nametable side
	input  ppu_addr_t ppu_addr,
	input  logic      cfg_mir_v,
	output logic      ciram_a10,
	output logic      ciram_ce,
	// Save state
	input  logic      sst_act,
	input  logic      sst_we,
	input  sst_addr_t sst_addr,
	input  cpu_data_t sst_wdata,
	output cpu_data_t sst_rdata
);

	logic      prg_valid;
	logic      prg_ready;
	prg_addr_t prg_addr;

	cpu_req_if req_bus ();

	cpu_req_port u_port
	(
		.m2        (m2),
		.reset     (reset),
		.cpu_valid (cpu_valid),
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.cpu_wdata (cpu_wdata),
		.cpu_ready (cpu_ready),
		.req       (req_bus.src)
	);

	mapper_071 u_mapper
	(
		.m2        (m2),
		.reset     (reset),
		.req       (req_bus.sink),
		.prg_valid (prg_valid),
		.prg_ready (prg_ready),
		.prg_addr  (prg_addr),
		.ppu_addr  (ppu_addr),
		.cfg_mir_v (cfg_mir_v),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.sst_act   (sst_act),
		.sst_we    (sst_we),
		.sst_addr  (sst_addr),
		.sst_wdata (sst_wdata),
		.sst_rdata (sst_rdata)
	);

	prg_fetch u_fetch
	(
		.m2            (m2),
		.reset         (reset),
		.prg_valid     (prg_valid),
		.prg_ready     (prg_ready),
		.prg_addr      (prg_addr),
		.prg_mem_addr  (prg_mem_addr),
		.prg_mem_rdata (prg_mem_rdata),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp_data      (rsp_data)
	);

endmodule

// File: source/prg_fetch.sv
`timescale 1ns/1ns

module prg_fetch
	import cart_pkg::*;
(
	input  logic      m2,
	input  logic      reset,
	input  logic      prg_valid,
	output logic      prg_ready,
	input  prg_addr_t prg_addr,
	output prg_addr_t prg_mem_addr,
	input  cpu_data_t prg_mem_rdata,
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output cpu_data_t rsp_data
);

	logic addr_valid;
	logic data_valid;
	logic rsp_free;
	logic addr_move;
	logic addr_load;

	assign rsp_free = !rsp_valid || rsp_ready;

	// The memory cannot hold its output, so a read only leaves the address
	// stage when the response register is sure to be empty a cycle later
	assign addr_move = addr_valid && !data_valid && rsp_free;
	assign prg_ready = !addr_valid || addr_move;
	assign addr_load = prg_valid && prg_ready;

	always_ff @(posedge m2)
	begin
		if (reset)
		begin
			addr_valid <= 1'b0;
			data_valid <= 1'b0;
			rsp_valid  <= 1'b0;
		end
		else
		begin
			if (addr_load)
				addr_valid <= 1'b1;
			else if (addr_move)
				addr_valid <= 1'b0;

			// Memory read in flight
			data_valid <= addr_move;

			if (data_valid)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge m2)
	begin
		if (addr_load)
			prg_mem_addr <= prg_addr;
		if (data_valid)
			rsp_data <= prg_mem_rdata;
	end

	// Held response must not change under back-pressure
	assert property (@(posedge m2) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

// File: source/mapper_071.sv
`timescale 1ns/1ns

module mapper_071
	import cart_pkg::*;
(
	input  logic      m2,
	input  logic      reset,
	cpu_req_if.sink   req,
	output logic      prg_valid,
	input  logic      prg_ready,
	output prg_addr_t prg_addr,
	input  ppu_addr_t ppu_addr,
	input  logic      cfg_mir_v,
	output logic      ciram_a10,
	output logic      ciram_ce,
	input  logic      sst_act,
	input  logic      sst_we,
	input  sst_addr_t sst_addr,
	input  cpu_data_t sst_wdata,
	output cpu_data_t sst_rdata
);

	prg_bank_t prg_bank;
	logic      mir_control_on;
	logic      mirror_mode;
	prg_bank_t bank_sel;
	logic      req_fire;
	logic      bank_wr;
	logic      mirror_wr;
	logic      sst_load;
	cpu_data_t regs_packed;

	// Reads wait on the fetch stage, register writes never stall
	assign req.ready = (req.region == REGION_PRG_READ) ? prg_ready : 1'b1;
	assign req_fire  = req.valid && req.ready;

	// CPU writes are swallowed while a save state is active
	assign bank_wr   = req_fire && req.region == REGION_BANK_WRITE && !sst_act;
	assign mirror_wr = req_fire && req.region == REGION_MIRROR_WRITE && !sst_act;
	assign sst_load  = sst_act && sst_we && sst_addr == SST_ADDR_REGS;

	// $8000 window is switchable, $C000 is pinned to the last bank
	assign bank_sel  = req.addr[PRG_WINDOW_W] ? '1 : prg_bank;
	assign prg_addr  = {bank_sel, req.addr[PRG_WINDOW_W-1:0]};
	assign prg_valid = req.valid && req.region == REGION_PRG_READ;

	always_ff @(posedge m2)
	begin
		if (reset)
		begin
			prg_bank       <= '0;
			mir_control_on <= 1'b0;
		end
		else if (sst_load)
		begin
			prg_bank       <= sst_wdata[PRG_BANK_W-1:0];
			mir_control_on <= sst_wdata[SST_MIR_ON_BIT];
		end
		else
		begin
			if (bank_wr)
				prg_bank <= req.data[PRG_BANK_W-1:0];
			if (mirror_wr)
				mir_control_on <= 1'b1;
		end
	end

	// Only meaningful once the override is on
	always_ff @(posedge m2)
	begin
		if (sst_load)
			mirror_mode <= sst_wdata[SST_MIR_MODE_BIT];
		else if (mirror_wr)
			mirror_mode <= req.data[4];
	end

	// A10 selects vertical mirroring, A11 horizontal
	assign ciram_a10 = mir_control_on ? mirror_mode : cfg_mir_v ? ppu_addr[10] : ppu_addr[11];
	assign ciram_ce  = !ppu_addr[13];

	always_comb
	begin
		regs_packed                   = '0;
		regs_packed[SST_MIR_MODE_BIT] = mirror_mode;
		regs_packed[SST_MIR_ON_BIT]   = mir_control_on;
		regs_packed[PRG_BANK_W-1:0]   = prg_bank;
	end

	always_comb
	begin
		if (sst_addr == SST_ADDR_REGS)
			sst_rdata = regs_packed;
		else if (sst_addr == SST_ADDR_ID)
			sst_rdata = MAPPER_ID;
		else
			sst_rdata = '1;
	end

	// Port decode must never tag a write as a PRG read
	assert property (@(posedge m2) disable iff (reset)
		req.valid && req.region == REGION_PRG_READ |-> req.rw);

endmodule

// File: source/cpu_req_port.sv
`timescale 1ns/1ns

module cpu_req_port
	import cart_pkg::*;
(
	input  logic      m2,
	input  logic      reset,
	input  logic      cpu_valid,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_rw,
	input  cpu_data_t cpu_wdata,
	output logic      cpu_ready,
	cpu_req_if.src    req
);

	logic        hit;
	cpu_region_t region;
	logic        take;

	// Address decode, anything not listed here is ignored by the board
	always_comb
	begin
		hit    = 1'b1;
		region = REGION_PRG_READ;
		if (cpu_rw && cpu_addr[15])
			region = REGION_PRG_READ;
		else if (!cpu_rw && cpu_addr[15:14] == 2'b11)
			region = REGION_BANK_WRITE;
		else if (!cpu_rw && cpu_addr[15:12] == 4'b1001)
			region = REGION_MIRROR_WRITE;
		else
			hit = 1'b0;
	end

	// Single entry, free again on the cycle it is taken
	assign cpu_ready = !req.valid || req.ready;
	assign take      = cpu_valid && cpu_ready;

	always_ff @(posedge m2)
	begin
		if (reset)
			req.valid <= 1'b0;
		else if (take)
			req.valid <= hit;
		else if (req.ready)
			req.valid <= 1'b0;
	end

	// Payload only moves when a new request is taken
	always_ff @(posedge m2)
	begin
		if (take)
		begin
			req.addr   <= cpu_addr;
			req.rw     <= cpu_rw;
			req.data   <= cpu_wdata;
			req.region <= region;
		end
	end

	// A stalled request keeps its payload until the mapper takes it
	assert property (@(posedge m2) disable iff (reset)
		req.valid && !req.ready |=> req.valid && $stable(req.addr) && $stable(req.rw)
			&& $stable(req.data) && $stable(req.region));

endmodule

// File: source/cpu_req_if.sv
`timescale 1ns/1ns

// Decoded CPU request travelling from the input port to the mapper
interface cpu_req_if
	import cart_pkg::*;
();

	logic        valid;
	logic        ready;
	cpu_addr_t   addr;
	logic        rw;
	cpu_data_t   data;
	cpu_region_t region;

	// Port side, owns the payload
	modport src
	(
		output valid,
		output addr,
		output rw,
		output data,
		output region,
		input  ready
	);

	// Mapper side, only answers with ready
	modport sink
	(
		input  valid,
		input  addr,
		input  rw,
		input  data,
		input  region,
		output ready
	);

endinterface

// File: source/cart_pkg.sv
package cart_pkg;

	localparam int CPU_ADDR_W = 16;
	localparam int CPU_DATA_W = 8;
	localparam int PRG_ADDR_W = 18;
	localparam int PRG_BANK_W = 4;
	localparam int PPU_ADDR_W = 14;
	localparam int SST_ADDR_W = 8;
	localparam int REGION_W   = 2;

	// Size of one 16 KB PRG window in address bits
	localparam int PRG_WINDOW_W = 14;

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [CPU_DATA_W-1:0] cpu_data_t;
	typedef logic [PRG_ADDR_W-1:0] prg_addr_t;
	typedef logic [PRG_BANK_W-1:0] prg_bank_t;
	typedef logic [PPU_ADDR_W-1:0] ppu_addr_t;
	typedef logic [SST_ADDR_W-1:0] sst_addr_t;
	typedef logic [REGION_W-1:0]   cpu_region_t;

	// Mapper number reported through the save-state port
	localparam cpu_data_t MAPPER_ID = 8'd71;

	// Request classes after address decode
	localparam cpu_region_t REGION_PRG_READ     = 2'd0;
	localparam cpu_region_t REGION_BANK_WRITE   = 2'd1;
	localparam cpu_region_t REGION_MIRROR_WRITE = 2'd2;

	// Save-state register map
	localparam sst_addr_t SST_ADDR_REGS = 8'd0;
	localparam sst_addr_t SST_ADDR_ID   = 8'd127;

	// Bit positions inside the packed register byte
	localparam int SST_MIR_MODE_BIT = 7;
	localparam int SST_MIR_ON_BIT   = 6;

endpackage
